/* iram_boot.f */
+incdir+common
common/iram_boot_pkg.sv
spi_rx/spi_byte_rx.sv
source/iram_load_fsm.sv
source/iram_lane_cnt.sv
source/iram_mem.sv
source/iram_boot_top.sv
bench/iram_boot_tb.sv

/* Bender.yml */
package:
  name: iram_boot

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/iram_boot_pkg.sv
      - spi_rx/spi_byte_rx.sv
      - source/iram_load_fsm.sv
      - source/iram_lane_cnt.sv
      - source/iram_mem.sv
      - source/iram_boot_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/iram_boot_tb.sv

/* bench/iram_boot_tb.sv */
`timescale 1ns/1ns
// ==========================================================
// SCLK is driven at clk_i/8, one byte per chip select frame.
// Only words 0 to 2 are modelled and read back.
// ==========================================================
module iram_boot_tb
    import iram_boot_pkg::*;
();

`include "iram_boot_params.svh"

    localparam int CLK_NS      = 100;
    localparam int TOTAL_BYTES = 37;
    localparam int WATCHDOG_NS = (TOTAL_BYTES * 64 + 2000) * CLK_NS;
    localparam int MODEL_WORDS = 3;

    logic       clk_i = 1'b1;  // Set before time 0, so no edge at start.
    logic       rst_n_i;
    logic       spi_sclk;
    logic       spi_mosi;
    logic       spi_cs_n;
    logic       spi_dc;
    iram_addr_t rd_addr;
    iram_word_t rd_data;
    logic       load_busy;
    logic       load_done;

    iram_word_t model_mem [MODEL_WORDS];
    int         model_addr;
    int         model_lane;  // 0 is the most significant lane.
    logic       model_busy;
    logic       model_done;
    integer     seed;

    iram_boot_top UUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .spi_sclk_i  (spi_sclk),
        .spi_mosi_i  (spi_mosi),
        .spi_cs_n_i  (spi_cs_n),
        .spi_dc_i    (spi_dc),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (rd_data),
        .load_busy_o (load_busy),
        .load_done_o (load_done)
    );

    always #(CLK_NS / 2) clk_i = ~clk_i;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Run stopped at %0t ns.", $time);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    assert property (@(posedge clk_i) !(load_busy && load_done))
        else stop_run("load_busy_o and load_done_o were high in the same cycle");

    assert property (@(posedge clk_i) !rst_n_i |-> (!load_busy && !load_done))
        else stop_run("A load flag was high while reset was asserted");

    initial begin
        #(WATCHDOG_NS);
        stop_run($sformatf("Timeout after %0d ns without finishing the tests", WATCHDOG_NS));
    end

    // One byte per chip select frame, MSB first.
    task automatic shift_byte(input byte_t value, input logic is_data);
        @(negedge clk_i);
        spi_cs_n = 1'b0;
        spi_dc   = is_data;
        for (int i = 7; i >= 0; i--) begin
            spi_sclk = 1'b0;
            spi_mosi = value[i];
            repeat (4) @(negedge clk_i);
            spi_sclk = 1'b1;
            repeat (4) @(negedge clk_i);
        end
        spi_sclk = 1'b0;
        spi_cs_n = 1'b1;
        repeat (4) @(negedge clk_i);
    endtask

    task automatic check_flags();
        assert (load_busy === model_busy)
            else report_mismatch("load_busy_o", model_busy, load_busy);
        assert (load_done === model_done)
            else report_mismatch("load_done_o", model_done, load_done);
    endtask

    task automatic send_cmd(input byte_t code);
        shift_byte(code, 1'b0);
        if (code == `CMD_RAM_WR_START) begin
            model_busy = 1'b1;
            model_done = 1'b0;
            model_addr = 0;
            model_lane = 0;
        end else if (code == `CMD_RAM_WR_STOP) begin
            model_done = model_busy;
            model_busy = 1'b0;
        end else begin
            model_busy = 1'b0;  // Abort.
            model_done = 1'b0;
        end
        repeat (10) @(negedge clk_i);
        check_flags();
    endtask

    task automatic send_data(input byte_t value);
        shift_byte(value, 1'b1);
        if (model_busy) begin
            model_mem[model_addr][(3 - model_lane) * 8 +: 8] = value;
            model_lane = model_lane + 1;
            if (model_lane == 4) begin
                model_lane = 0;
                model_addr = model_addr + 1;
            end
        end
        repeat (10) @(negedge clk_i);
        check_flags();
    endtask

    task automatic send_random(input int count);
        integer rnd;
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            send_data(rnd[7:0]);
        end
    endtask

    task automatic check_word(input int addr);
        iram_word_t exp;
        @(negedge clk_i);
        rd_addr = iram_addr_t'(addr);
        @(negedge clk_i);  // Registered read.
        exp = model_mem[addr];
        assert (!$isunknown(rd_data))
            else stop_run($sformatf("rd_data_o holds unknown bits at word %0d", addr));
        assert (rd_data === exp)
            else report_mismatch($sformatf("rd_data_o word %0d", addr), exp, rd_data);
    endtask

    task automatic check_words_0_to_2();
        for (int a = 0; a < 3; a++) begin
            check_word(a);
        end
    endtask

    initial begin
        rst_n_i    = 1'b1;
        spi_sclk   = 1'b0;
        spi_mosi   = 1'b0;
        spi_cs_n   = 1'b1;
        spi_dc     = 1'b0;
        rd_addr    = '0;
        seed       = 32'ha51f_0636;
        model_addr = 0;
        model_lane = 0;
        model_busy = 1'b0;
        model_done = 1'b0;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            model_mem[i] = 'x;
        end

        // Reset and idle flags.
        @(negedge clk_i);
        rst_n_i = 1'b0;
        repeat (8) @(negedge clk_i);
        check_flags();
        assert (rd_data === '0)
            else report_mismatch("rd_data_o in reset", 32'h0, rd_data);
        rst_n_i = 1'b1;
        repeat (2) @(negedge clk_i);
        check_flags();

        // Full load of three words.
        send_cmd(`CMD_RAM_WR_START);
        send_random(12);
        send_cmd(`CMD_RAM_WR_STOP);
        check_words_0_to_2();

        // Shorter reload, word 1 only half replaced.
        send_cmd(`CMD_RAM_WR_START);
        send_random(6);
        send_cmd(`CMD_RAM_WR_STOP);
        check_words_0_to_2();

        // Stray data after stop.
        send_random(4);
        check_words_0_to_2();
        send_cmd(`CMD_RAM_WR_START);

        // Aborted load.
        send_cmd(`CMD_RAM_WR_START);
        send_random(3);
        send_cmd(8'h55);
        send_random(4);
        check_words_0_to_2();

        // Stop while idle.
        send_cmd(`CMD_RAM_WR_STOP);

        $display("All tests passed");
        $finish;
    end

endmodule

/* source/iram_boot_top.sv */
`timescale 1ns/1ns
// ==========================================================
// Serial boot loader into instruction RAM.
// SCLK must run at clk_i/8 or slower.
// ==========================================================
module iram_boot_top
    import iram_boot_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       spi_sclk_i,
    input  logic       spi_mosi_i,
    input  logic       spi_cs_n_i,
    input  logic       spi_dc_i,

    input  iram_addr_t rd_addr_i,
    output iram_word_t rd_data_o,

    output logic       load_busy_o,
    output logic       load_done_o
);

    logic       rx_req;
    logic       rx_ack;
    byte_t      rx_byte;
    logic       rx_dc;
    logic       lane_clr;
    logic       lane_step;
    logic       wr_en;
    byte_t      wr_data;
    iram_addr_t wr_addr;
    lane_en_t   wr_lane_en;

    spi_byte_rx u_rx (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .spi_sclk_i (spi_sclk_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_dc_i   (spi_dc_i),
        .ack_i      (rx_ack),
        .req_o      (rx_req),
        .byte_o     (rx_byte),
        .dc_o       (rx_dc)
    );

    iram_load_fsm u_fsm (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (rx_req),
        .byte_i      (rx_byte),
        .dc_i        (rx_dc),
        .ack_o       (rx_ack),
        .lane_clr_o  (lane_clr),
        .lane_step_o (lane_step),
        .wr_en_o     (wr_en),
        .wr_data_o   (wr_data),
        .load_busy_o (load_busy_o),
        .load_done_o (load_done_o)
    );

    iram_lane_cnt u_lane (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .clr_i     (lane_clr),
        .step_i    (lane_step),
        .lane_en_o (wr_lane_en),
        .addr_o    (wr_addr)
    );

    iram_mem u_mem (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wr_en_i      (wr_en),
        .wr_addr_i    (wr_addr),
        .wr_lane_en_i (wr_lane_en),
        .wr_data_i    (wr_data),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o)
    );

endmodule

/* source/iram_mem.sv */
`timescale 1ns/1ns
// ==========================================================
// Array contents are unknown until written.
// Read data appears one clock after rd_addr_i.
// ==========================================================
module iram_mem
    import iram_boot_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       wr_en_i,
    input  iram_addr_t wr_addr_i,
    input  lane_en_t   wr_lane_en_i,
    input  byte_t      wr_data_i,

    input  iram_addr_t rd_addr_i,
    output iram_word_t rd_data_o
);

`include "iram_boot_params.svh"

    localparam int LANE_W = `IRAM_DW / `IRAM_LANES;

    iram_word_t mem_q [2**`IRAM_AW];

    // One lane per write, no replication.
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `IRAM_LANES; i++) begin
            if (wr_en_i && wr_lane_en_i[i]) begin
                mem_q[wr_addr_i][i*LANE_W +: LANE_W] <= wr_data_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o <= '0;
        end else begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

endmodule

/* source/iram_lane_cnt.sv */
`timescale 1ns/1ns
// ==========================================================
// Lanes fill from most to least significant byte.
// The word address wraps at the top of the RAM.
// ==========================================================
module iram_lane_cnt
    import iram_boot_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       clr_i,
    input  logic       step_i,

    output lane_en_t   lane_en_o,
    output iram_addr_t addr_o
);

`include "iram_boot_params.svh"

    localparam lane_en_t LANE_MSB = lane_en_t'(1) << (`IRAM_LANES - 1);

    lane_en_t   lane_q;
    iram_addr_t addr_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lane_q <= LANE_MSB;
            addr_q <= '0;
        end else if (clr_i) begin
            lane_q <= LANE_MSB;
            addr_q <= '0;
        end else if (step_i) begin
            lane_q <= {lane_q[0], lane_q[`IRAM_LANES-1:1]};
            if (lane_q[0]) begin
                addr_q <= addr_q + 1'b1;  // Word complete.
            end
        end
    end

    assign lane_en_o = lane_q;
    assign addr_o    = addr_q;

endmodule

/* source/iram_load_fsm.sv */
`timescale 1ns/1ns
// ==========================================================
// D/C low marks a command byte, high a data byte.
// Data bytes outside an active load are dropped.
// ==========================================================
module iram_load_fsm
    import iram_boot_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,

    input  logic  req_i,
    input  byte_t byte_i,
    input  logic  dc_i,
    output logic  ack_o,

    output logic  lane_clr_o,
    output logic  lane_step_o,
    output logic  wr_en_o,
    output byte_t wr_data_o,

    output logic  load_busy_o,
    output logic  load_done_o
);

`include "iram_boot_params.svh"

    load_state_t state_q;
    logic        req_new;

    assign req_new = req_i & ~ack_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= LD_IDLE;
            ack_o       <= 1'b0;
            lane_clr_o  <= 1'b0;
            lane_step_o <= 1'b0;
            wr_en_o     <= 1'b0;
        end else begin
            lane_clr_o  <= 1'b0;  // Single-cycle pulses.
            lane_step_o <= 1'b0;
            wr_en_o     <= 1'b0;

            if (req_new) begin
                ack_o <= 1'b1;
                if (!dc_i) begin
                    case (byte_i)
                        `CMD_RAM_WR_START: begin
                            state_q    <= LD_ACTIVE;
                            lane_clr_o <= 1'b1;
                        end
                        `CMD_RAM_WR_STOP: begin
                            state_q <= (state_q == LD_ACTIVE) ? LD_DONE : LD_IDLE;
                        end
                        default: begin
                            state_q <= LD_IDLE;  // Abort.
                        end
                    endcase
                end else if (state_q == LD_ACTIVE) begin
                    wr_en_o     <= 1'b1;
                    lane_step_o <= 1'b1;
                end
            end else if (ack_o && !req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_new) begin
            wr_data_o <= byte_i;
        end
    end

    assign load_busy_o = (state_q == LD_ACTIVE);
    assign load_done_o = (state_q == LD_DONE);

endmodule

/* spi_rx/spi_byte_rx.sv */
`timescale 1ns/1ns
// ==========================================================
// Pins are async to clk_i; SCLK must not exceed clk_i/8.
// A byte ending while a request is still open is dropped.
// ==========================================================
module spi_byte_rx
    import iram_boot_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,

    input  logic  spi_sclk_i,
    input  logic  spi_mosi_i,
    input  logic  spi_cs_n_i,
    input  logic  spi_dc_i,

    input  logic  ack_i,
    output logic  req_o,
    output byte_t byte_o,
    output logic  dc_o
);

    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] cs_n_sync;
    logic [1:0] dc_sync;
    logic       sclk_prev;
    logic       sclk_rise;
    logic [2:0] bit_cnt;
    logic [6:0] shift_q;
    logic       byte_done;
    logic       byte_take;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            cs_n_sync <= 2'b11;  // Deselected.
            dc_sync   <= 2'b00;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
            cs_n_sync <= {cs_n_sync[0], spi_cs_n_i};
            dc_sync   <= {dc_sync[0], spi_dc_i};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign byte_done = sclk_rise & ~cs_n_sync[1] & (bit_cnt == 3'd7);
    assign byte_take = byte_done & ~req_o & ~ack_i;  // Only with the handshake idle.

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt <= 3'd0;
        end else if (cs_n_sync[1]) begin
            bit_cnt <= 3'd0;
        end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;  // Wraps after bit 7.
        end
    end

    always_ff @(posedge clk_i) begin
        if (sclk_rise && !cs_n_sync[1]) begin
            shift_q <= {shift_q[5:0], mosi_sync[1]};  // MSB first.
        end
    end

    // Sender side of the four-phase handshake.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_o <= 1'b0;
        end else if (req_o && ack_i) begin
            req_o <= 1'b0;
        end else if (byte_take) begin
            req_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (byte_take) begin
            byte_o <= {shift_q, mosi_sync[1]};
            dc_o   <= dc_sync[1];  // D/C taken with bit 8.
        end
    end

endmodule

/* common/iram_boot_pkg.sv */
// ==========================================================
// Shared types of the loader. Widths come from the
// params header, which is pulled in here.
// ==========================================================
package iram_boot_pkg;

`include "iram_boot_params.svh"

    typedef logic [7:0]             byte_t;       // One serial byte.
    typedef logic [`IRAM_AW-1:0]    iram_addr_t;  // Word address.
    typedef logic [`IRAM_DW-1:0]    iram_word_t;  // One RAM word.
    typedef logic [`IRAM_LANES-1:0] lane_en_t;    // One-hot lane.

    typedef enum logic [1:0] {
        LD_IDLE   = 2'd0,
        LD_ACTIVE = 2'd1,
        LD_DONE   = 2'd2
    } load_state_t;

endpackage

/* common/iram_boot_params.svh */
// ==========================================================
// Sizes and command codes for the instruction RAM loader.
// The lane count must divide IRAM_DW into 8-bit lanes.
// ==========================================================
`ifndef IRAM_BOOT_PARAMS_SVH
`define IRAM_BOOT_PARAMS_SVH

// RAM geometry.
`define IRAM_AW    13
`define IRAM_DW    32
`define IRAM_LANES 4

// Command bytes, sent with D/C low.
`define CMD_RAM_WR_START 8'h2A
`define CMD_RAM_WR_STOP  8'h2B

`endif
